//--- logic/game_defines.svh
/*
 * Screen geometry, sprite boxes, barrel steps and game constants.
 * Included by the lane and health modules that need the numbers.
 */

`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// Visible area in pixels
`define SCREEN_W     1024
`define SCREEN_H     768

// Sprite boxes
`define BARREL_SIZE  32
`define PLAYER_W     48
`define PLAYER_H     64

// Pixels per frame strobe
`define HOR_STEP     16
`define VER_STEP     8

`define LANE_SLOTS   5
`define START_LIVES  3

`endif

//--- logic/game_pkg.sv
/*
 * Types shared by the barrel game core.
 * Modules import it inside their body and use scoped names on ports.
 */

`default_nettype none

package game_pkg;

   // Screen coordinate, wide enough for a step past the right edge
   typedef logic [10:0] pos_t;

   // Lives left for player 1
   typedef logic [1:0] lives_t;

   typedef enum logic {
      PLAYING,
      GAME_OVER
   } game_state_t;

endpackage

`default_nettype wire

//--- logic/health_tracker.sv
/*
 * Lives counter and game state for player 1.
 * Each lane hit costs one life, down to zero, where the game ends
 * until the next reset.
 */

`timescale 1ns/10ps
`default_nettype none

`include "game_defines.svh"

module health_tracker (
   input  logic                  clk65MHz,
   input  logic                  reset,
   input  logic                  hor_hit,
   input  logic                  ver_hit,
   output game_pkg::lives_t      lives,
   output game_pkg::game_state_t game_state
);

   import game_pkg::*;

   lives_t loss;
   lives_t lives_nxt;

   // Both lanes may hit on the same frame
   assign loss = lives_t'(hor_hit) + lives_t'(ver_hit);

   assign lives_nxt = (lives > loss) ? lives - loss : '0;

   always_ff @(posedge clk65MHz) begin
      if (reset) begin
         lives      <= lives_t'(`START_LIVES);
         game_state <= PLAYING;
      end else begin
         case (game_state)
            PLAYING: begin
               lives <= lives_nxt;
               if (lives_nxt == '0) begin
                  game_state <= GAME_OVER;
               end
            end
            GAME_OVER: begin
               game_state <= GAME_OVER;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- logic/barrel_lane.sv
/*
 * One barrel lane. Launches enter the lowest free slot through a valid/ready
 * handshake, every active barrel steps on each frame strobe, and a barrel is
 * freed when it leaves the screen or overlaps player 1. VERTICAL picks the
 * axis of travel; lane_hit pulses for one cycle after a hitting frame.
 */

`timescale 1ns/10ps
`default_nettype none

`include "game_defines.svh"

module barrel_lane #(
   parameter int VERTICAL = 0,
   parameter int SLOTS    = `LANE_SLOTS
) (
   input  logic                 clk65MHz,
   input  logic                 reset,
   input  logic                 frame,
   input  game_pkg::pos_t       player_x,
   input  game_pkg::pos_t       player_y,
   input  logic                 launch_valid,
   input  game_pkg::pos_t       launch_pos,
   input  game_pkg::game_state_t game_state,
   output logic                 launch_ready,
   output logic                 lane_hit
);

   import game_pkg::*;

   localparam int STEP = (VERTICAL != 0) ? `VER_STEP : `HOR_STEP;
   localparam int EDGE = (VERTICAL != 0) ? `SCREEN_H : `SCREEN_W;

   logic [SLOTS-1:0] active;
   logic [SLOTS-1:0] new_slot;
   logic [SLOTS-1:0] exits;
   logic [SLOTS-1:0] hits;

   // Position along the lane and across it
   pos_t along  [SLOTS];
   pos_t across [SLOTS];

   // One bit wider so that box edges past the screen do not wrap
   logic [11:0] next_along [SLOTS];
   logic [11:0] box_x      [SLOTS];
   logic [11:0] box_y      [SLOTS];
   logic [11:0] player_x_w;
   logic [11:0] player_y_w;

   logic accept;
   logic move;

   assign move   = frame && (game_state == PLAYING);
   assign accept = launch_valid && launch_ready;

   assign launch_ready = (~active != '0) && (game_state == PLAYING);

   // Lowest clear bit of active, as a one-hot mask
   assign new_slot = ~active & (active + SLOTS'(1));

   assign player_x_w = {1'b0, player_x};
   assign player_y_w = {1'b0, player_y};

   always_comb begin
      for (int i = 0; i < SLOTS; i++) begin
         next_along[i] = {1'b0, along[i]} + 12'(STEP);
         exits[i]      = next_along[i] >= 12'(EDGE);

         if (VERTICAL != 0) begin
            box_x[i] = {1'b0, across[i]};
            box_y[i] = next_along[i];
         end else begin
            box_x[i] = next_along[i];
            box_y[i] = {1'b0, across[i]};
         end

         // Strict intersection on both axes
         hits[i] = active[i] && !exits[i] &&
                   (box_x[i] < player_x_w + 12'(`PLAYER_W)) &&
                   (player_x_w < box_x[i] + 12'(`BARREL_SIZE)) &&
                   (box_y[i] < player_y_w + 12'(`PLAYER_H)) &&
                   (player_y_w < box_y[i] + 12'(`BARREL_SIZE));
      end
   end

   // Slot occupancy
   always_ff @(posedge clk65MHz) begin
      for (int i = 0; i < SLOTS; i++) begin
         if (reset) begin
            active[i] <= 1'b0;
         end else if (move && active[i]) begin
            if (exits[i] || hits[i]) begin
               active[i] <= 1'b0;
            end
         end else if (accept && new_slot[i]) begin
            active[i] <= 1'b1;
         end
      end
   end

   // Barrel positions
   always_ff @(posedge clk65MHz) begin
      for (int i = 0; i < SLOTS; i++) begin
         if (accept && new_slot[i]) begin
            along[i]  <= '0;
            across[i] <= launch_pos;
         end else if (move && active[i]) begin
            along[i] <= next_along[i][10:0];
         end
      end
   end

   always_ff @(posedge clk65MHz) begin
      if (reset) begin
         lane_hit <= 1'b0;
      end else begin
         lane_hit <= move && (hits != '0);
      end
   end

endmodule

`default_nettype wire

//--- logic/barrel_game.sv
/*
 * Top level of the barrel game core.
 * A horizontal and a vertical barrel lane report hits on player 1 to the
 * health tracker, whose game state in turn stops both lanes.
 */

`timescale 1ns/10ps
`default_nettype none

module barrel_game (
   input  logic             clk65MHz,
   input  logic             reset,
   input  logic             frame,
   input  game_pkg::pos_t   player_x,
   input  game_pkg::pos_t   player_y,
   input  logic             hor_launch_valid,
   input  game_pkg::pos_t   hor_launch_pos,
   output logic             hor_launch_ready,
   input  logic             ver_launch_valid,
   input  game_pkg::pos_t   ver_launch_pos,
   output logic             ver_launch_ready,
   output game_pkg::lives_t lives,
   output logic             game_over,
   output logic             hit
);

   import game_pkg::*;

   logic        hor_hit;
   logic        ver_hit;
   game_state_t game_state;

   assign game_over = (game_state == GAME_OVER);
   assign hit       = hor_hit | ver_hit;

   // Barrels rolling right along a row
   barrel_lane #(
      .VERTICAL(0)
   ) u_hor_lane (
      .clk65MHz,
      .reset,
      .frame,
      .player_x,
      .player_y,
      .launch_valid(hor_launch_valid),
      .launch_pos(hor_launch_pos),
      .game_state,
      .launch_ready(hor_launch_ready),
      .lane_hit(hor_hit)
   );

   // Barrels dropping down a column
   barrel_lane #(
      .VERTICAL(1)
   ) u_ver_lane (
      .clk65MHz,
      .reset,
      .frame,
      .player_x,
      .player_y,
      .launch_valid(ver_launch_valid),
      .launch_pos(ver_launch_pos),
      .game_state,
      .launch_ready(ver_launch_ready),
      .lane_hit(ver_hit)
   );

   health_tracker u_health_tracker (
      .clk65MHz,
      .reset,
      .hor_hit,
      .ver_hit,
      .lives,
      .game_state
   );

endmodule

`default_nettype wire

//--- tb/barrel_game_assertions.sv
/*
 * Concurrent checks on the barrel game top level, attached with bind.
 * Covers hit pulse width, the lives count and ready in GAME_OVER.
 */

`timescale 1ns/10ps
`default_nettype none

module barrel_game_assertions (
   input logic             clk65MHz,
   input logic             reset,
   input logic             hit,
   input game_pkg::lives_t lives,
   input logic             game_over,
   input logic             hor_launch_ready,
   input logic             ver_launch_ready
);

   // Hits are one-cycle pulses
   hit_single_cycle: assert property (@(posedge clk65MHz) disable iff (reset)
      hit |=> !hit)
      else $error("hit was high in two consecutive cycles");

   lives_never_rise: assert property (@(posedge clk65MHz)
      (!reset && !$past(reset)) |-> (lives <= $past(lives)))
      else $error("lives increased outside reset");

   no_ready_when_over: assert property (@(posedge clk65MHz) disable iff (reset)
      game_over |-> (!hor_launch_ready && !ver_launch_ready))
      else $error("launch ready high in GAME_OVER");

endmodule

`default_nettype wire

//--- tb/barrel_game_tb.sv
/*
 * Testbench for the barrel game core. Reads one test step per record from
 * tb/barrel_testdata.txt, drives player position, launches and frame strobes,
 * then checks lives, game_over, both ready outputs and the hit pulse count.
 * Prints one line per test and a closing line with the counts.
 */

`timescale 1ns/10ps
`default_nettype none

module barrel_game_tb;

   import game_pkg::*;

   // Record layout in the data file
   localparam int NUM_FIELDS = 15;
   localparam int MAX_STEPS  = 32;
   localparam int FRAME_GAP  = 8;

   logic   clk65MHz = 1'b0;
   logic   reset;
   logic   frame;
   pos_t   player_x;
   pos_t   player_y;
   logic   hor_launch_valid;
   pos_t   hor_launch_pos;
   logic   hor_launch_ready;
   logic   ver_launch_valid;
   pos_t   ver_launch_pos;
   logic   ver_launch_ready;
   lives_t lives;
   logic   game_over;
   logic   hit;

   logic [15:0] step_data [MAX_STEPS*NUM_FIELDS];
   logic [15:0] cur       [NUM_FIELDS];

   integer seed        = 32'h5eb7_fa52;
   int     cycle_count = 0;
   int     cycle_limit = 1000000;
   int     hit_total   = 0;
   int     num_steps;
   int     test_errors;
   int     tests_passed;
   int     tests_failed;

   always #2 clk65MHz = ~clk65MHz;

   barrel_game dut_i (
      .clk65MHz(clk65MHz),
      .reset(reset),
      .frame(frame),
      .player_x(player_x),
      .player_y(player_y),
      .hor_launch_valid(hor_launch_valid),
      .hor_launch_pos(hor_launch_pos),
      .hor_launch_ready(hor_launch_ready),
      .ver_launch_valid(ver_launch_valid),
      .ver_launch_pos(ver_launch_pos),
      .ver_launch_ready(ver_launch_ready),
      .lives(lives),
      .game_over(game_over),
      .hit(hit)
   );

   bind barrel_game barrel_game_assertions u_barrel_game_assertions (
      .clk65MHz(clk65MHz),
      .reset(reset),
      .hit(hit),
      .lives(lives),
      .game_over(game_over),
      .hor_launch_ready(hor_launch_ready),
      .ver_launch_ready(ver_launch_ready)
   );

   always @(posedge clk65MHz) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("Timeout: a launch or test step never finished within %0d clock cycles",
                  cycle_limit);
         $display("Simulation failed");
         $finish;
      end
   end

   // Hit pulses, counted where the output is stable
   always @(negedge clk65MHz) begin
      if (hit) begin
         hit_total = hit_total + 1;
      end
   end

   task automatic apply_reset();
      @(negedge clk65MHz);
      reset            = 1'b1;
      frame            = 1'b0;
      hor_launch_valid = 1'b0;
      ver_launch_valid = 1'b0;
      repeat (10) @(negedge clk65MHz);
      reset = 1'b0;
   endtask

   task automatic launch_barrels(input bit vertical, input int count, input pos_t pos);
      int idle;
      for (int n = 0; n < count; n++) begin
         idle = $random(seed) & 7;
         repeat (idle) @(negedge clk65MHz);
         if (vertical) begin
            ver_launch_valid = 1'b1;
            ver_launch_pos   = pos;
            while (!ver_launch_ready) @(negedge clk65MHz);
         end else begin
            hor_launch_valid = 1'b1;
            hor_launch_pos   = pos;
            while (!hor_launch_ready) @(negedge clk65MHz);
         end
         // Accepted on the rising edge in between
         @(negedge clk65MHz);
         if (vertical) begin
            ver_launch_valid = 1'b0;
         end else begin
            hor_launch_valid = 1'b0;
         end
      end
   endtask

   task automatic pulse_frames(input int count);
      repeat (count) begin
         repeat (FRAME_GAP - 1) @(negedge clk65MHz);
         frame = 1'b1;
         @(negedge clk65MHz);
         frame = 1'b0;
      end
   endtask

   task automatic report_mismatch(input string what, input int got, input int expected);
      $display("FAILED at %0t: test %0d, %s is %0d, expected %0d",
               $time, int'(cur[0]), what, got, expected);
      test_errors++;
   endtask

   task automatic check_step(input int hits_seen);
      if (lives !== cur[10][1:0]) begin
         report_mismatch("lives", int'(lives), int'(cur[10]));
      end
      if (game_over !== cur[11][0]) begin
         report_mismatch("game_over", int'(game_over), int'(cur[11]));
      end
      if (hor_launch_ready !== cur[12][0]) begin
         report_mismatch("hor_launch_ready", int'(hor_launch_ready), int'(cur[12]));
      end
      if (ver_launch_ready !== cur[13][0]) begin
         report_mismatch("ver_launch_ready", int'(ver_launch_ready), int'(cur[13]));
      end
      if (hits_seen != int'(cur[14])) begin
         report_mismatch("hit pulse count", hits_seen, int'(cur[14]));
      end
   endtask

   initial begin
      int total_frames;
      int total_launches;
      int hits_before;
      int base;

      reset            = 1'b1;
      frame            = 1'b0;
      player_x         = '0;
      player_y         = '0;
      hor_launch_valid = 1'b0;
      hor_launch_pos   = '0;
      ver_launch_valid = 1'b0;
      ver_launch_pos   = '0;

      for (int i = 0; i < MAX_STEPS*NUM_FIELDS; i++) begin
         step_data[i] = 16'hffff;
      end
      $readmemh("tb/barrel_testdata.txt", step_data);

      num_steps      = 0;
      total_frames   = 0;
      total_launches = 0;
      while (num_steps < MAX_STEPS && step_data[num_steps*NUM_FIELDS] != 16'hffff) begin
         base           = num_steps * NUM_FIELDS;
         total_frames   = total_frames + int'(step_data[base + 9]);
         total_launches = total_launches + int'(step_data[base + 5]) +
                          int'(step_data[base + 7]);
         num_steps++;
      end

      // Frame spacing, launch slack, then resets and checks
      cycle_limit = total_frames * FRAME_GAP + total_launches * 16 + num_steps * 32 + 200;

      tests_passed = 0;
      tests_failed = 0;
      test_errors  = 0;

      apply_reset();

      for (int s = 0; s < num_steps; s++) begin
         for (int f = 0; f < NUM_FIELDS; f++) begin
            cur[f] = step_data[s*NUM_FIELDS + f];
         end
         if (cur[1][0]) begin
            apply_reset();
         end
         player_x    = cur[3][10:0];
         player_y    = cur[4][10:0];
         hits_before = hit_total;

         if (cur[2][0]) begin
            // Launches may stall on ready while frames keep running
            fork
               begin
                  launch_barrels(1'b0, int'(cur[5]), cur[6][10:0]);
                  launch_barrels(1'b1, int'(cur[7]), cur[8][10:0]);
               end
               pulse_frames(int'(cur[9]));
            join
         end else begin
            launch_barrels(1'b0, int'(cur[5]), cur[6][10:0]);
            launch_barrels(1'b1, int'(cur[7]), cur[8][10:0]);
            pulse_frames(int'(cur[9]));
         end

         repeat (4) @(negedge clk65MHz);
         check_step(hit_total - hits_before);

         if (s == num_steps - 1 || step_data[(s+1)*NUM_FIELDS] != cur[0]) begin
            if (test_errors == 0) begin
               $display("Test %0d passed", int'(cur[0]));
               tests_passed++;
            end else begin
               $display("Test %0d failed with %0d errors", int'(cur[0]), test_errors);
               tests_failed++;
            end
            test_errors = 0;
         end
      end

      $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && num_steps > 0) begin
         $display("Simulation completed successfully");
      end else begin
         if (num_steps == 0) begin
            $display("No test steps were found in tb/barrel_testdata.txt");
         end
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tb/barrel_testdata.txt
// Hex fields: test reset mode player_x player_y hor_count hor_pos ver_count ver_pos frames
// Then expected: lives game_over hor_ready ver_ready hit_pulses (mode 1 = frames during launches)

// Reset state
01 0 0 0C8 12C 0 000 0 000 00 3 0 1 1 0

// Horizontal barrel on row 600 still in lane after 63 frames, gone on the 64th
02 0 0 0C8 12C 1 258 0 000 3F 3 0 1 1 0
02 0 0 0C8 12C 4 258 0 000 00 3 0 0 1 0
02 0 0 0C8 12C 0 000 0 000 01 3 0 1 1 0

// Player at x 200, barrel on the player's row hits on frame 11
03 0 0 0C8 12C 1 12C 0 000 0B 2 0 1 1 1

// Vertical lane fills, sixth launch waits for the exits on frame 96
04 0 0 0C8 12C 0 000 5 258 00 2 0 1 0 0
04 0 1 0C8 12C 0 000 1 258 64 2 0 1 1 0
04 0 0 0C8 12C 0 000 4 258 00 2 0 1 0 0

// Both lanes reach the player on frame 11, two lives in one hit pulse
05 1 0 0C8 070 1 070 1 0C8 0A 3 0 1 1 0
05 0 0 0C8 070 0 000 0 000 01 1 0 1 1 1

// Third hit ends the game, frames change nothing until reset
06 0 0 0C8 070 1 070 0 000 0B 0 1 0 0 1
06 0 0 0C8 070 0 000 0 000 14 0 1 0 0 0
06 1 0 0C8 070 0 000 0 000 00 3 0 1 1 0

//--- flist.f
+incdir+logic
logic/game_pkg.sv
logic/health_tracker.sv
logic/barrel_lane.sv
logic/barrel_game.sv
tb/barrel_game_assertions.sv
tb/barrel_game_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the barrel game testbench with Verilator and run it.
# The exit status is zero only when the pass message appears in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module barrel_game_tb \
   -Mdir obj_dir -o barrel_game_sim \
   && ./obj_dir/barrel_game_sim | tee /dev/stderr \
      | grep -q "Simulation completed successfully" \
   && echo "Run passed" \
   || { echo "Run failed"; exit 1; }
